// ==== hdl/dcore_pkg.sv ====
package dcore_pkg;

    // number of time-interleaved ADC slices
    localparam int N_TI = 4;

    // unfolded code width
    localparam int N_ADC = 8;

    // raw slice magnitude, sign comes separately
    localparam int N_MAG = N_ADC - 1;

    // width of the PRBS bit counters
    localparam int N_COUNT = 32;

    // raw magnitude of one slice
    typedef logic [N_MAG-1:0] mag_t;

    // signed unfolded code, also offset and threshold
    typedef logic signed [N_ADC-1:0] code_t;

    // checker counter value
    typedef logic [N_COUNT-1:0] count_t;

endpackage

// ==== hdl/adc_unfold.sv ====
module adc_unfold #(
    parameter int n_ti = dcore_pkg::N_TI
) (
    input  logic                             clk_adc,
    input  logic                             rst_n_i,
    input  logic                             adc_valid_i,
    input  logic                             prbs_clr_i,
    input  logic [n_ti*dcore_pkg::N_MAG-1:0] adcout_i,
    input  logic [n_ti-1:0]                  adcout_sign_i,
    input  dcore_pkg::code_t                 offset_i,
    output logic [n_ti*dcore_pkg::N_ADC-1:0] code_word_o,
    output logic                             code_valid_o,
    output logic                             code_clr_o
);

    import dcore_pkg::*;

    // two guard bits hold +/-mag minus offset without overflow
    typedef logic signed [N_ADC+1:0] wide_t;

    localparam wide_t SAT_HI = wide_t'(2**(N_ADC-1) - 1);
    localparam wide_t SAT_LO = -wide_t'(2**(N_ADC-1));

    logic [n_ti*N_MAG-1:0] mag_q;
    logic [n_ti-1:0]       sign_q;
    logic                  valid_q;
    logic                  clr_q;
    logic [n_ti*N_ADC-1:0] code_next;

    // sign bit set means positive code
    function automatic code_t unfold_slice(input mag_t mag, input logic sign,
                                           input code_t offset);
        wide_t mag_ext;
        wide_t sum;
        mag_ext = wide_t'(mag);
        sum = sign ? mag_ext : -mag_ext;
        sum = sum - wide_t'(offset);
        if (sum > SAT_HI) begin
            return code_t'(SAT_HI);
        end
        if (sum < SAT_LO) begin
            return code_t'(SAT_LO);
        end
        return code_t'(sum);
    endfunction

    // stage 1: capture the raw word
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            clr_q   <= 1'b0;
        end else begin
            valid_q <= adc_valid_i;
            clr_q   <= adc_valid_i & prbs_clr_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (adc_valid_i) begin
            mag_q  <= adcout_i;
            sign_q <= adcout_sign_i;
        end
    end

    always_comb begin
        for (int i = 0; i < n_ti; i++) begin
            code_next[i*N_ADC +: N_ADC] = unfold_slice(mag_q[i*N_MAG +: N_MAG], sign_q[i],
                                                       offset_i);
        end
    end

    // stage 2: signed, offset-corrected codes
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            code_valid_o <= 1'b0;
            code_clr_o   <= 1'b0;
        end else begin
            code_valid_o <= valid_q;
            code_clr_o   <= clr_q;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (valid_q) begin
            code_word_o <= code_next;
        end
    end

endmodule

// ==== hdl/snapshot_memory.sv ====
module snapshot_memory #(
    parameter int n_ti = dcore_pkg::N_TI,
    parameter int snap_depth = 16,
    localparam int addr_w = $clog2(snap_depth)
) (
    input  logic                             clk_adc,
    input  logic                             rst_n_i,
    input  logic [n_ti*dcore_pkg::N_ADC-1:0] code_word_i,
    input  logic                             code_valid_i,
    input  logic                             dump_start_i,
    input  logic [addr_w-1:0]                rd_addr_i,
    output logic [n_ti*dcore_pkg::N_ADC-1:0] rd_data_o,
    output logic                             dump_done_o
);

    import dcore_pkg::*;

    typedef logic [n_ti*N_ADC-1:0] word_t;

    localparam logic [addr_w-1:0] LAST_ADDR = addr_w'(snap_depth - 1);

    word_t             mem [snap_depth];
    logic              armed;
    logic [addr_w-1:0] wr_ptr;
    logic              wr_en;

    // the word arriving with the start strobe is not part of the burst
    assign wr_en = armed & code_valid_i & ~dump_start_i;

    // capture control
    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            armed       <= 1'b0;
            wr_ptr      <= '0;
            dump_done_o <= 1'b0;
        end else begin
            if (dump_start_i) begin
                // also restarts a capture in progress
                armed       <= 1'b1;
                wr_ptr      <= '0;
                dump_done_o <= 1'b0;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_ptr == LAST_ADDR) begin
                    armed       <= 1'b0;
                    dump_done_o <= 1'b1;
                end
            end
        end
    end

    // storage array
    always_ff @(posedge clk_adc) begin
        if (wr_en) begin
            mem[wr_ptr] <= code_word_i;
        end
    end

    // registered readback, any cycle
    always_ff @(posedge clk_adc) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== hdl/prbs_checker.sv ====
module prbs_checker #(
    parameter int n_ti = dcore_pkg::N_TI
) (
    input  logic                             clk_adc,
    input  logic                             rst_n_i,
    input  logic [n_ti*dcore_pkg::N_ADC-1:0] code_word_i,
    input  logic                             code_valid_i,
    input  logic                             code_clr_i,
    input  dcore_pkg::code_t                 thresh_i,
    output dcore_pkg::count_t                err_bits_o,
    output dcore_pkg::count_t                total_bits_o
);

    import dcore_pkg::*;

    // x^7 + x^6 + 1
    localparam int PRBS_LEN = 7;
    localparam int fill_w = $clog2(PRBS_LEN + 1);
    localparam int cnt_w = $clog2(n_ti + 1);

    logic [n_ti-1:0]     rx_bits;
    logic [PRBS_LEN-1:0] hist_q;
    logic [PRBS_LEN-1:0] hist_next;
    logic [fill_w-1:0]   fill_q;
    logic [fill_w-1:0]   fill_next;
    logic [cnt_w-1:0]    n_chk;
    logic [cnt_w-1:0]    n_err;
    count_t              total_base;
    count_t              err_base;

    // data slicer, signed compare
    always_comb begin
        for (int i = 0; i < n_ti; i++) begin
            rx_bits[i] = code_t'(code_word_i[i*N_ADC +: N_ADC]) > thresh_i;
        end
    end

    // walk the word in slice order
    // hist bit 0 is the newest received bit
    always_comb begin
        hist_next = code_clr_i ? '0 : hist_q;
        fill_next = code_clr_i ? '0 : fill_q;
        n_chk = '0;
        n_err = '0;
        for (int i = 0; i < n_ti; i++) begin
            if (fill_next == fill_w'(PRBS_LEN)) begin
                n_chk = n_chk + 1'b1;
                // prediction from the bits 7 and 6 back
                if (rx_bits[i] != (hist_next[PRBS_LEN-1] ^ hist_next[PRBS_LEN-2])) begin
                    n_err = n_err + 1'b1;
                end
            end else begin
                fill_next = fill_next + 1'b1;
            end
            hist_next = {hist_next[PRBS_LEN-2:0], rx_bits[i]};
        end
    end

    // a new run starts the counters from zero
    assign total_base = code_clr_i ? '0 : total_bits_o;
    assign err_base   = code_clr_i ? '0 : err_bits_o;

    always_ff @(posedge clk_adc or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hist_q       <= '0;
            fill_q       <= '0;
            total_bits_o <= '0;
            err_bits_o   <= '0;
        end else if (code_valid_i) begin
            hist_q       <= hist_next;
            fill_q       <= fill_next;
            total_bits_o <= total_base + count_t'(n_chk);
            err_bits_o   <= err_base + count_t'(n_err);
        end
    end

endmodule

// ==== hdl/digital_core.sv ====
module digital_core #(
    parameter int n_ti = dcore_pkg::N_TI,
    parameter int snap_depth = 16,
    localparam int addr_w = $clog2(snap_depth)
) (
    input  logic                             clk_adc,
    input  logic                             rst_n_i,
    input  logic [n_ti*dcore_pkg::N_MAG-1:0] adcout_i,
    input  logic [n_ti-1:0]                  adcout_sign_i,
    input  logic                             adc_valid_i,
    input  logic                             prbs_clr_i,
    input  dcore_pkg::code_t                 offset_i,
    input  dcore_pkg::code_t                 thresh_i,
    input  logic                             dump_start_i,
    input  logic [addr_w-1:0]                rd_addr_i,
    output logic [n_ti*dcore_pkg::N_ADC-1:0] rd_data_o,
    output logic                             dump_done_o,
    output dcore_pkg::count_t                err_bits_o,
    output dcore_pkg::count_t                total_bits_o
);

    import dcore_pkg::*;

    // unfolded code stream, shared by both consumers
    logic [n_ti*N_ADC-1:0] code_word;
    logic                  code_valid;
    logic                  code_clr;

    adc_unfold #(
        .n_ti(n_ti)
    ) adc_unfold_inst (
        .clk_adc      (clk_adc),
        .rst_n_i      (rst_n_i),
        .adc_valid_i  (adc_valid_i),
        .prbs_clr_i   (prbs_clr_i),
        .adcout_i     (adcout_i),
        .adcout_sign_i(adcout_sign_i),
        .offset_i     (offset_i),
        .code_word_o  (code_word),
        .code_valid_o (code_valid),
        .code_clr_o   (code_clr)
    );

    // one-shot capture of the unfolded codes
    snapshot_memory #(
        .n_ti      (n_ti),
        .snap_depth(snap_depth)
    ) snapshot_memory_inst (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .code_word_i (code_word),
        .code_valid_i(code_valid),
        .dump_start_i(dump_start_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .dump_done_o (dump_done_o)
    );

    // slicer and PRBS7 check
    prbs_checker #(
        .n_ti(n_ti)
    ) prbs_checker_inst (
        .clk_adc     (clk_adc),
        .rst_n_i     (rst_n_i),
        .code_word_i (code_word),
        .code_valid_i(code_valid),
        .code_clr_i  (code_clr),
        .thresh_i    (thresh_i),
        .err_bits_o  (err_bits_o),
        .total_bits_o(total_bits_o)
    );

endmodule

// ==== tb/tb_digital_core.sv ====
module tb_digital_core;

    import dcore_pkg::*;

    localparam int SNAP_DEPTH = 16;
    localparam int ADDR_W = $clog2(SNAP_DEPTH);

    logic                  clk_adc;
    logic                  rst_n_i;
    logic [N_TI*N_MAG-1:0] adcout_i;
    logic [N_TI-1:0]       adcout_sign_i;
    logic                  adc_valid_i;
    logic                  prbs_clr_i;
    code_t                 offset_i;
    code_t                 thresh_i;
    logic                  dump_start_i;
    logic [ADDR_W-1:0]     rd_addr_i;
    logic [N_TI*N_ADC-1:0] rd_data_o;
    logic                  dump_done_o;
    count_t                err_bits_o;
    count_t                total_bits_o;

    integer seed;
    int     errors;
    int     err_mark;
    int     passed;
    int     failed;

    // reference model state
    logic [N_TI*N_ADC-1:0] snap_exp[$];
    bit                    snap_armed;
    bit                    run_bits[$];
    count_t                exp_total;
    count_t                exp_err;
    logic [6:0]            gen_state;

    digital_core #(
        .n_ti      (N_TI),
        .snap_depth(SNAP_DEPTH)
    ) digital_core_inst (
        .clk_adc      (clk_adc),
        .rst_n_i      (rst_n_i),
        .adcout_i     (adcout_i),
        .adcout_sign_i(adcout_sign_i),
        .adc_valid_i  (adc_valid_i),
        .prbs_clr_i   (prbs_clr_i),
        .offset_i     (offset_i),
        .thresh_i     (thresh_i),
        .dump_start_i (dump_start_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .dump_done_o  (dump_done_o),
        .err_bits_o   (err_bits_o),
        .total_bits_o (total_bits_o)
    );

    always #5 clk_adc = ~clk_adc;

    // sign 1 gives a positive code before offset removal and clipping to 8 bits
    function automatic int unfold_ref(input int mag, input bit sign, input int offset);
        int v;
        v = (sign ? mag : -mag) - offset;
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
        return v;
    endfunction

    // PRBS7 source for x^7 + x^6 + 1
    function automatic bit prbs_bit();
        bit b;
        b = gen_state[6] ^ gen_state[5];
        gen_state = {gen_state[5:0], b};
        return b;
    endfunction

    task automatic model_word(input logic [N_TI*N_MAG-1:0] mag, input logic [N_TI-1:0] sign,
                              input bit clr);
        logic [N_TI*N_ADC-1:0] word;
        int                    code;
        bit                    b;
        if (clr) begin
            exp_total = '0;
            exp_err = '0;
            run_bits.delete();
        end
        for (int i = 0; i < N_TI; i++) begin
            code = unfold_ref(int'(mag[i*N_MAG +: N_MAG]), sign[i], int'(offset_i));
            word[i*N_ADC +: N_ADC] = code[N_ADC-1:0];
            b = code > int'(thresh_i);
            // queue holds the last seven bits with the oldest first
            if (run_bits.size() == 7) begin
                exp_total++;
                if (b != (run_bits[0] ^ run_bits[1])) begin
                    exp_err++;
                end
                void'(run_bits.pop_front());
            end
            run_bits.push_back(b);
        end
        if (snap_armed) begin
            snap_exp.push_back(word);
            snap_armed = snap_exp.size() < SNAP_DEPTH;
        end
    endtask

    task automatic send_raw(input logic [N_TI*N_MAG-1:0] mag, input logic [N_TI-1:0] sign,
                            input bit clr);
        @(posedge clk_adc);
        #1;
        adc_valid_i = 1'b1;
        prbs_clr_i = clr;
        dump_start_i = 1'b0;
        adcout_i = mag;
        adcout_sign_i = sign;
        model_word(mag, sign, clr);
    endtask

    // gap cycles carry junk data with the strobe low
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_adc);
            #1;
            adc_valid_i = 1'b0;
            prbs_clr_i = 1'b0;
            dump_start_i = 1'b0;
            adcout_i = (N_TI*N_MAG)'($random(seed));
            adcout_sign_i = N_TI'($random(seed));
        end
    endtask

    task automatic send_prbs(input int n_words, input int flip_mod, input int mag_lo,
                             input int mag_hi);
        logic [N_TI*N_MAG-1:0] mag;
        logic [N_TI-1:0]       bits;
        for (int w = 0; w < n_words; w++) begin
            for (int i = 0; i < N_TI; i++) begin
                bits[i] = prbs_bit();
                if (flip_mod > 0 && ($random(seed) % flip_mod) == 0) begin
                    bits[i] = ~bits[i];
                end
                mag[i*N_MAG +: N_MAG] =
                    N_MAG'(mag_lo + ($unsigned($random(seed)) % (mag_hi - mag_lo + 1)));
            end
            send_raw(mag, bits, w == 0);
        end
    endtask

    task automatic start_capture();
        @(posedge clk_adc);
        #1;
        adc_valid_i = 1'b0;
        dump_start_i = 1'b1;
        snap_exp.delete();
        snap_armed = 1'b1;
        idle(1);
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (dump_done_o !== 1'b1 && n < limit) begin
            @(posedge clk_adc);
            #1;
            n++;
        end
        if (dump_done_o !== 1'b1) begin
            $display("Timeout: dump_done_o did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic check_snapshot();
        for (int a = 0; a < snap_exp.size(); a++) begin
            rd_addr_i = ADDR_W'(a);
            @(posedge clk_adc);
            #1;
            if (rd_data_o !== snap_exp[a]) begin
                $display("Error at time %0t: rd_data_o[%0d] expected %h, actual %h",
                         $time, a, snap_exp[a], rd_data_o);
                errors++;
            end
        end
    endtask

    task automatic check_counters();
        if (total_bits_o !== exp_total) begin
            $display("Error at time %0t: total_bits_o expected %0d, actual %0d",
                     $time, exp_total, total_bits_o);
            errors++;
        end
        if (err_bits_o !== exp_err) begin
            $display("Error at time %0t: err_bits_o expected %0d, actual %0d",
                     $time, exp_err, err_bits_o);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: FAIL, %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        seed = 38;
        errors = 0;
        err_mark = 0;
        passed = 0;
        failed = 0;
        snap_armed = 1'b0;
        exp_total = '0;
        exp_err = '0;
        gen_state = 7'h7f;
        clk_adc = 1'b0;
        rst_n_i = 1'b0;
        adcout_i = '0;
        adcout_sign_i = '0;
        adc_valid_i = 1'b0;
        prbs_clr_i = 1'b0;
        offset_i = '0;
        thresh_i = '0;
        dump_start_i = 1'b0;
        rd_addr_i = '0;
        repeat (3) @(posedge clk_adc);
        #1;
        rst_n_i = 1'b1;

        idle(2);
        if (dump_done_o !== 1'b0) begin
            $display("Error at time %0t: dump_done_o expected 0, actual %b", $time, dump_done_o);
            errors++;
        end
        check_counters();
        end_test("reset state");

        start_capture();
        for (int p = 0; p < 3; p++) begin
            // extreme offsets reach both clip limits
            offset_i = (p == 0) ? code_t'(-128) :
                       (p == 1) ? code_t'($random(seed) % 16) : code_t'(127);
            for (int w = 0; w < ((p == 1) ? 6 : 5); w++) begin
                send_raw((N_TI*N_MAG)'($random(seed)), N_TI'($random(seed)), 1'b0);
                if (($random(seed) & 3) == 0) begin
                    idle(1);
                end
            end
            idle(3);
        end
        wait_done(20);
        check_snapshot();
        check_counters();
        end_test("unfold and saturation");

        offset_i = '0;
        send_prbs(24, 0, 40, 100);
        idle(3);
        check_counters();
        if (total_bits_o !== count_t'(24*N_TI - 7)) begin
            $display("Error at time %0t: total_bits_o expected %0d, actual %0d",
                     $time, 24*N_TI - 7, total_bits_o);
            errors++;
        end
        if (err_bits_o !== '0) begin
            $display("Error at time %0t: err_bits_o expected 0, actual %0d",
                     $time, err_bits_o);
            errors++;
        end
        end_test("clean prbs run");

        send_prbs(40, 12, 40, 100);
        idle(3);
        check_counters();
        end_test("error counting");

        // codes of +/-5 sit between the outer thresholds
        for (int t = 0; t < 3; t++) begin
            thresh_i = (t == 0) ? code_t'(0) : (t == 1) ? code_t'(-20) : code_t'(20);
            send_prbs(10, 0, 5, 5);
            idle(3);
            check_counters();
        end
        thresh_i = '0;
        end_test("threshold dependence");

        start_capture();
        repeat (6) send_raw((N_TI*N_MAG)'($random(seed)), N_TI'($random(seed)), 1'b0);
        idle(3);
        start_capture();
        repeat (SNAP_DEPTH - 1) send_raw((N_TI*N_MAG)'($random(seed)), N_TI'($random(seed)), 1'b0);
        idle(3);
        if (dump_done_o !== 1'b0) begin
            $display("Error at time %0t: dump_done_o expected 0, actual %b", $time, dump_done_o);
            errors++;
        end
        send_raw((N_TI*N_MAG)'($random(seed)), N_TI'($random(seed)), 1'b0);
        idle(1);
        wait_done(20);
        check_snapshot();
        end_test("capture restart");

        $display("summary: %0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/dcore_pkg.sv
hdl/adc_unfold.sv
hdl/snapshot_memory.sv
hdl/prbs_checker.sv
hdl/digital_core.sv
tb/tb_digital_core.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the digital_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_digital_core -f tb.f -o tb_digital_core \
    && ./obj_dir/tb_digital_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
